//--- router.f
logic/nocPacketPkg.sv
logic/routerPortPkg.sv
logic/portRequestIf.sv
logic/inputUnit.sv
logic/switchAllocator.sv
logic/router.sv
verif/routerTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= routerTb
FILELIST  ?= router.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- verif/routerTb.sv
module routerTb;

  timeunit 1ns;
  timeprecision 1ps;

  import nocPacketPkg::*;
  import routerPortPkg::*;

  // Router sits in the middle of a 3 by 3 mesh
  localparam int meX       = 1;
  localparam int meY       = 1;
  localparam int meshSize  = 3;
  localparam int depth     = 4;
  localparam int waitLimit = 8;

  logic                 clk;
  logic                 reset;
  packetT               dataIn [portCount];
  logic [portCount-1:0] writeIn;
  logic [portCount-1:0] holdIn;
  packetT               dataOut [portCount];
  logic [portCount-1:0] writeOut;
  logic [portCount-1:0] holdOut;

  // Expected packets per output with the oldest first
  packetT               expQ [portCount][$];
  packetT               frontPkt [portCount];
  logic [portCount-1:0] frontValid;

  // Round-robin pointer per output as each expected departure moves it
  int rrModel [portCount];

  logic [31:0] lfsrState;
  int          mismatchCount;
  int          timeoutCount;

  // Enables for the latency and fill checks
  logic                 idleCheck;
  logic                 fillCheck;
  logic [portCount-1:0] expStrobe;
  int                   fillWrites;

  router #(
    .xLocation     (meX),
    .yLocation     (meY),
    .xNodes        (meshSize),
    .yNodes        (meshSize),
    .fifoDepth     (depth),
    .deadlockLimit (waitLimit)
  ) UUT (
    .clk      (clk),
    .reset    (reset),
    .dataIn   (dataIn),
    .writeIn  (writeIn),
    .holdIn   (holdIn),
    .dataOut  (dataOut),
    .writeOut (writeOut),
    .holdOut  (holdOut)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] randBits(int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int b = 0; b < n; b++)
    begin
      fb        = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
      lfsrState = {lfsrState[30:0], fb};
      v         = {v[30:0], fb};
    end
    return v;
  endfunction

  // X is resolved before y and local means home
  function automatic int xyPort(int dx, int dy);
    if (dx > meX)
      return int'(portEast);
    if (dx < meX)
      return int'(portWest);
    if (dy > meY)
      return int'(portNorth);
    if (dy < meY)
      return int'(portSouth);
    return int'(portLocal);
  endfunction

  function automatic packetT makePacket(int src, int dx, int dy, int rr);
    packetT p;
    p.destX    = coordWidth'(dx);
    p.destY    = coordWidth'(dy);
    p.hopCount = hopWidth'(randBits(hopWidth));
    p.reroute  = rerouteWidth'(rr);
    // Source input sits in the low payload bits
    p.payload  = (payloadWidth'(randBits(32)) << 3) | payloadWidth'(src);
    return p;
  endfunction

  task automatic refreshFront(int o);
    frontValid[o] = (expQ[o].size() != 0);
    if (frontValid[o])
      frontPkt[o] = expQ[o][0];
  endtask

  // One hop added and reroute lowered by what the path spends
  task automatic expectOut(int o, packetT p, int spent);
    packetT e;
    e          = p;
    e.hopCount = p.hopCount + 1'b1;
    e.reroute  = p.reroute - rerouteWidth'(spent);
    expQ[o].push_back(e);
    refreshFront(o);
  endtask

  task automatic nextCycle();
    @(posedge clk);
    #1;
  endtask

  task automatic clearInputs();
    writeIn   = '0;
    expStrobe = '0;
  endtask

  task automatic sendOne(int src, packetT p, int o, int spent);
    expectOut(o, p, spent);
    dataIn[src]  = p;
    writeIn[src] = 1'b1;
    expStrobe[o] = 1'b1;
  endtask

  task automatic waitDrain(int limit);
    int n;
    n = 0;
    while ((frontValid != '0) && (n < limit))
    begin
      nextCycle();
      n++;
    end
    if (frontValid != '0)
    begin
      timeoutCount++;
      $display("Timed out at %0t waiting for expected packets to leave the router", $time);
    end
  endtask

  task automatic waitHold(int p, int limit);
    int n;
    n = 0;
    while (!holdOut[p] && (n < limit))
    begin
      nextCycle();
      n++;
    end
    if (!holdOut[p])
    begin
      timeoutCount++;
      $display("Timed out at %0t waiting for hold on input %0d", $time, p);
    end
  endtask

  // One packet at a time to every node of the mesh
  task automatic routingTest();
    int     src;
    packetT p;
    idleCheck = 1'b1;
    for (int dx = 0; dx < meshSize; dx++)
    begin
      for (int dy = 0; dy < meshSize; dy++)
      begin
        src = int'(randBits(3)) % portCount;
        p   = makePacket(src, dx, dy, int'(randBits(rerouteWidth)));
        sendOne(src, p, xyPort(dx, dy), 0);
        nextCycle();
        clearInputs();
        repeat (int'(randBits(2))) nextCycle();
        waitDrain(20);
      end
    end
    repeat (2) nextCycle();
    idleCheck = 1'b0;
  endtask

  // Two packets from each sender to local are granted in turn from the pointer
  task automatic contentionTest(portMaskT senders);
    packetT p [2][portCount];
    int     start;
    int     i;
    start = rrModel[portLocal];
    for (int r = 0; r < 2; r++)
    begin
      for (int k = 0; k < portCount; k++)
      begin
        i       = (start + k) % portCount;
        p[r][i] = makePacket(i, meX, meY, int'(randBits(rerouteWidth)));
        if (senders[i])
          expectOut(int'(portLocal), p[r][i], 0);
      end
    end
    for (int r = 0; r < 2; r++)
    begin
      for (int s = 0; s < portCount; s++)
      begin
        dataIn[s]  = p[r][s];
        writeIn[s] = senders[s];
      end
      nextCycle();
    end
    clearInputs();
    waitDrain(40);
  endtask

  // West input fills behind a held east output with no reroute budget
  task automatic holdTest();
    holdIn[portEast] = 1'b1;
    fillWrites       = 0;
    nextCycle();
    fillCheck = 1'b1;
    while (fillWrites < depth)
    begin
      sendOne(int'(portWest), makePacket(int'(portWest), meX + 1, meY, 0), int'(portEast), 0);
      fillWrites++;
      nextCycle();
    end
    clearInputs();
    waitHold(int'(portWest), 5);
    // Write into a full FIFO that must be dropped
    dataIn[portWest]  = makePacket(int'(portWest), meX + 1, meY, 0);
    writeIn[portWest] = 1'b1;
    nextCycle();
    clearInputs();
    repeat (waitLimit + 4) nextCycle();
    fillCheck = 1'b0;
    holdIn    = '0;
    waitDrain(40);
  endtask

  // Each mesh direction is held in turn and the head leaves clockwise with one reroute spent
  task automatic misrouteTest();
    int     alt;
    packetT p;
    for (int d = int'(portNorth); d <= int'(portWest); d++)
    begin
      alt      = (d == int'(portWest)) ? int'(portNorth) : d + 1;
      holdIn[d] = 1'b1;
      p = makePacket(int'(portLocal),
                     meX + int'(d == int'(portEast)) - int'(d == int'(portWest)),
                     meY + int'(d == int'(portNorth)) - int'(d == int'(portSouth)),
                     1 + int'(randBits(2)));
      sendOne(int'(portLocal), p, alt, 1);
      nextCycle();
      clearInputs();
      waitDrain(waitLimit + 10);
      holdIn = '0;
      nextCycle();
    end
  endtask

  // Scoreboard pops what left on the previous cycle
  always @(posedge clk)
  begin
    for (int o = 0; o < portCount; o++)
    begin
      if (reset)
        rrModel[o] = 0;
      else if (writeOut[o])
      begin
        // Pointer moves one past the source of the packet expected here
        if (expQ[o].size() != 0)
        begin
          rrModel[o] = (int'(frontPkt[o].payload[2:0]) + 1) % portCount;
          void'(expQ[o].pop_front());
        end
        refreshFront(o);
      end
    end
  end

  for (genvar o = 0; o < portCount; o++)
  begin : gCheck
    // Departing packet must be the oldest one expected on that port
    assert property (@(negedge clk) disable iff (reset)
      writeOut[o] |-> (frontValid[o] && (dataOut[o] == frontPkt[o])))
    else
    begin
      mismatchCount++;
      $display("mismatch at %0t: output %0d gave %h, expected %h (pending %b)",
               $time, o, dataOut[o], frontPkt[o], frontValid[o]);
    end

    assert property (@(negedge clk) disable iff (reset) $past(holdIn[o]) |-> !writeOut[o])
    else
    begin
      mismatchCount++;
      $display("mismatch at %0t: output %0d wrote while held", $time, o);
    end
  end

  // On an idle router the strobe out comes exactly one clock after the strobe in
  assert property (@(negedge clk) disable iff (reset)
    idleCheck |-> (writeOut == $past(expStrobe, 2)))
  else
  begin
    mismatchCount++;
    $display("mismatch at %0t: writeOut %b not one clock after the input strobe",
             $time, writeOut);
  end

  // Hold goes up once the FIFO holds depth packets
  assert property (@(negedge clk) disable iff (reset)
    fillCheck |-> (holdOut[portWest] == ($past(fillWrites) >= depth)))
  else
  begin
    mismatchCount++;
    $display("mismatch at %0t: west holdOut %b with %0d writes sent",
             $time, holdOut[portWest], fillWrites);
  end

  assert property (@(negedge clk) (reset || $past(reset)) |-> (writeOut == '0 && holdOut == '0))
  else
  begin
    mismatchCount++;
    $display("mismatch at %0t: writeOut %b holdOut %b around reset", $time, writeOut, holdOut);
  end

  initial
  begin
    reset         = 1'b1;
    writeIn       = '0;
    holdIn        = '0;
    expStrobe     = '0;
    frontValid    = '0;
    idleCheck     = 1'b0;
    fillCheck     = 1'b0;
    fillWrites    = 0;
    mismatchCount = 0;
    timeoutCount  = 0;
    lfsrState     = 32'hfbb2;
    for (int o = 0; o < portCount; o++)
    begin
      dataIn[o]   = '0;
      frontPkt[o] = '0;
      rrModel[o]  = 0;
    end
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    routingTest();
    for (int n = 0; n < 3; n++)
      contentionTest(portMaskT'(randBits(portCount)) | 5'b10010);
    holdTest();
    misrouteTest();
    repeat (3) nextCycle();
    $display("Checks done: %0d mismatches, %0d timeouts", mismatchCount, timeoutCount);
    if ((mismatchCount == 0) && (timeoutCount == 0))
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

//--- logic/router.sv
module router #(
  parameter int xLocation     = 0,
  parameter int yLocation     = 0,
  parameter int xNodes        = 2,
  parameter int yNodes        = 2,
  parameter int fifoDepth     = 4,
  parameter int deadlockLimit = 8
) (
  input  logic                               clk,
  input  logic                               reset,
  input  nocPacketPkg::packetT               dataIn [routerPortPkg::portCount],
  input  logic [routerPortPkg::portCount-1:0] writeIn,
  input  logic [routerPortPkg::portCount-1:0] holdIn,
  output nocPacketPkg::packetT               dataOut [routerPortPkg::portCount],
  output logic [routerPortPkg::portCount-1:0] writeOut,
  output logic [routerPortPkg::portCount-1:0] holdOut
);

  import nocPacketPkg::*;
  import routerPortPkg::*;

  // One request link per input unit
  portRequestIf reqIf [portCount] ();

  // Packets after the hop increment, on their way into the FIFOs
  packetT dataInc [portCount];

  // Head packets and misroute flags pulled out of the links for the crossbar
  packetT headArr   [portCount];
  logic   unprodArr [portCount];

  // Allocator decision per output
  portSelT  sel [portCount];
  portMaskT outValid;

  // Crossbar result before the output register
  packetT xbarNext [portCount];

  for (genvar j = 0; j < portCount; j++)
  begin : gInput
    // Count this router as a hop
    always_comb
    begin
      dataInc[j]          = dataIn[j];
      dataInc[j].hopCount = dataIn[j].hopCount + 1'b1;
    end

    inputUnit #(
      .xLocation     (xLocation),
      .yLocation     (yLocation),
      .xNodes        (xNodes),
      .yNodes        (yNodes),
      .fifoDepth     (fifoDepth),
      .deadlockLimit (deadlockLimit)
    ) inputUnitInst (
      .clk     (clk),
      .reset   (reset),
      .dataIn  (dataInc[j]),
      .writeIn (writeIn[j]),
      .hold    (holdOut[j]),
      .req     (reqIf[j])
    );

    assign headArr[j]   = reqIf[j].headData;
    assign unprodArr[j] = reqIf[j].unproductive;
  end

  switchAllocator allocInst (
    .clk      (clk),
    .reset    (reset),
    .req      (reqIf),
    .holdIn   (holdIn),
    .sel      (sel),
    .outValid (outValid)
  );

  // Single mux layer, spend one reroute when the winner was misrouted
  always_comb
  begin
    for (int o = 0; o < portCount; o++)
    begin
      xbarNext[o] = headArr[sel[o]];
      if (unprodArr[sel[o]])
        xbarNext[o].reroute = headArr[sel[o]].reroute - 1'b1;
    end
  end

  // Output data only loads on a grant
  always_ff @(posedge clk)
  begin
    for (int o = 0; o < portCount; o++)
    begin
      if (outValid[o])
        dataOut[o] <= xbarNext[o];
    end
  end

  // Write strobe to each neighbour, one cycle per packet
  always_ff @(posedge clk)
  begin
    if (reset)
      writeOut <= '0;
    else
      writeOut <= outValid;
  end

endmodule

//--- logic/switchAllocator.sv
module switchAllocator (
  input  logic                      clk,
  input  logic                      reset,
  portRequestIf.allocSide           req [routerPortPkg::portCount],
  input  routerPortPkg::portMaskT   holdIn,
  output routerPortPkg::portSelT    sel [routerPortPkg::portCount],
  output routerPortPkg::portMaskT   outValid
);

  import routerPortPkg::*;

  // Requests gathered per input, row is input, column is output
  portMaskT reqMask [portCount];

  // Grant back to each input
  portMaskT grantVec;

  // Round-robin pointer per output, first input to look at
  portSelT rrPtr [portCount];

  // Interface arrays need constant indices
  for (genvar i = 0; i < portCount; i++)
  begin : gReq
    assign reqMask[i]   = req[i].request;
    assign req[i].grant = grantVec[i];
  end

  // Per output, pick the first requester at or after the pointer
  always_comb
  begin : pick
    int cand;
    cand = 0;
    for (int o = 0; o < portCount; o++)
    begin
      sel[o]      = '0;
      outValid[o] = 1'b0;
      // A held output grants nothing
      if (!holdIn[o])
      begin
        for (int k = 0; k < portCount; k++)
        begin
          cand = int'(rrPtr[o]) + k;
          if (cand >= portCount)
            cand = cand - portCount;
          if (!outValid[o] && reqMask[cand][o])
          begin
            outValid[o] = 1'b1;
            sel[o]      = portSelT'(cand);
          end
        end
      end
    end
  end

  // Each input requests one output, so it sees at most one grant here
  always_comb
  begin
    grantVec = '0;
    for (int i = 0; i < portCount; i++)
    begin
      for (int o = 0; o < portCount; o++)
      begin
        if (outValid[o] && (sel[o] == portSelT'(i)))
          grantVec[i] = 1'b1;
      end
    end
  end

  // Pointer moves to one past the winner, only on a grant
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int o = 0; o < portCount; o++)
        rrPtr[o] <= '0;
    end
    else
    begin
      for (int o = 0; o < portCount; o++)
      begin
        if (outValid[o])
        begin
          rrPtr[o] <= (sel[o] == portSelT'(portCount - 1)) ? '0 : sel[o] + 1'b1;
        end
      end
    end
  end

endmodule

//--- logic/inputUnit.sv
module inputUnit #(
  parameter int xLocation     = 0,
  parameter int yLocation     = 0,
  parameter int xNodes        = 2,
  parameter int yNodes        = 2,
  parameter int fifoDepth     = 4,
  parameter int deadlockLimit = 8
) (
  input  logic                 clk,
  input  logic                 reset,
  input  nocPacketPkg::packetT dataIn,
  input  logic                 writeIn,
  output logic                 hold,
  portRequestIf.inputSide      req
);

  import nocPacketPkg::*;
  import routerPortPkg::*;

  localparam int ptrWidth   = (fifoDepth > 1) ? $clog2(fifoDepth) : 1;
  localparam int countWidth = $clog2(fifoDepth + 1);
  localparam int waitWidth  = $clog2(deadlockLimit + 1);

  localparam logic [coordWidth-1:0] myX = coordWidth'(xLocation);
  localparam logic [coordWidth-1:0] myY = coordWidth'(yLocation);

  // Ports that lead to a neighbour on the mesh, local is never a misroute target
  localparam portMaskT legalMask = {
    xLocation > 0,
    yLocation > 0,
    xLocation < xNodes - 1,
    yLocation < yNodes - 1,
    1'b0
  };

  // Packet storage
  packetT mem [fifoDepth];

  logic [ptrWidth-1:0]   rdPtr;
  logic [ptrWidth-1:0]   wrPtr;
  logic [countWidth-1:0] count;
  logic [waitWidth-1:0]  waitCount;

  logic   empty;
  logic   push;
  logic   pop;
  logic   misroute;
  packetT head;
  portT   prodPort;
  portT   altPort;
  portT   outPort;

  assign empty = (count == '0);
  assign hold  = (count == countWidth'(fifoDepth));

  // Writes while full are dropped
  assign push = writeIn && !hold;
  // Allocator only grants a live request, so the FIFO is never empty here
  assign pop  = req.grant;

  assign head = mem[rdPtr];

  // Payload storage has no reset
  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem[wrPtr] <= dataIn;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
      begin
        wrPtr <= (wrPtr == ptrWidth'(fifoDepth - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (pop)
      begin
        rdPtr <= (rdPtr == ptrWidth'(fifoDepth - 1)) ? '0 : rdPtr + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      if (push && !pop)
      begin
        count <= count + 1'b1;
      end
      else if (pop && !push)
      begin
        count <= count - 1'b1;
      end
    end
  end

  // XY routing, resolve x first, then y
  always_comb
  begin
    if (head.destX > myX)
      prodPort = portEast;
    else if (head.destX < myX)
      prodPort = portWest;
    else if (head.destY > myY)
      prodPort = portNorth;
    else if (head.destY < myY)
      prodPort = portSouth;
    else
      prodPort = portLocal;
  end

  // First legal mesh port clockwise of the productive one
  always_comb
  begin : altSearch
    portT cand;
    logic found;
    cand    = prodPort;
    found   = 1'b0;
    altPort = prodPort;
    for (int k = 0; k < portCount - 2; k++)
    begin
      cand = clockwiseNext(cand);
      if (!found && legalMask[cand])
      begin
        altPort = cand;
        found   = 1'b1;
      end
    end
  end

  // Misroute only after a long wait, with budget left, and not for a packet already home
  assign misroute = !empty
                    && (waitCount == waitWidth'(deadlockLimit))
                    && (head.reroute != '0)
                    && (prodPort != portLocal)
                    && (altPort != prodPort);

  assign outPort = misroute ? altPort : prodPort;

  assign req.request      = empty ? '0 : portMask(outPort);
  assign req.unproductive = misroute;
  assign req.headData     = head;

  // Cycles the head has waited without a grant, saturating at the limit
  always_ff @(posedge clk)
  begin
    if (reset || pop)
    begin
      waitCount <= '0;
    end
    else if (!empty && (waitCount != waitWidth'(deadlockLimit)))
    begin
      waitCount <= waitCount + 1'b1;
    end
  end

endmodule

//--- logic/portRequestIf.sv
interface portRequestIf;

  import nocPacketPkg::*;
  import routerPortPkg::*;

  // One-hot output port wanted by the head packet, zero when empty
  portMaskT request;

  // Set while the request is a misroute away from the XY path
  logic unproductive;

  // Head of the input FIFO, read by the crossbar
  packetT headData;

  // Head pops on the edge where this is high
  logic grant;

  modport inputSide (
    output request,
    output unproductive,
    output headData,
    input  grant
  );

  modport allocSide (
    input  request,
    input  unproductive,
    input  headData,
    output grant
  );

endinterface

//--- logic/routerPortPkg.sv
package routerPortPkg;

  // Local plus the four mesh neighbours
  localparam int portCount = 5;

  // Index of one port
  typedef logic [$clog2(portCount)-1:0] portSelT;

  // One bit per port, bit index equals the port enum value
  typedef logic [portCount-1:0] portMaskT;

  // North is +y, east is +x
  typedef enum portSelT {
    portLocal,
    portNorth,
    portEast,
    portSouth,
    portWest
  } portT;

  // One-hot mask of a single port
  function automatic portMaskT portMask(portT p);
    return portMaskT'(1) << int'(p);
  endfunction

  // Next mesh port clockwise, local never comes back
  function automatic portT clockwiseNext(portT p);
    case (p)
      portNorth: return portEast;
      portEast:  return portSouth;
      portSouth: return portWest;
      default:   return portNorth;
    endcase
  endfunction

endpackage

//--- logic/nocPacketPkg.sv
package nocPacketPkg;

  // Mesh coordinate width, enough for up to a 16 by 16 mesh
  localparam int coordWidth = 4;

  // Hop counter, wraps silently on very long paths
  localparam int hopWidth = 8;

  // Remaining misroutes a packet may take
  localparam int rerouteWidth = 4;

  // Whatever is left of the 64-bit flit
  localparam int payloadWidth = 64 - 2 * coordWidth - hopWidth - rerouteWidth;

  // Single-flit packet as carried between routers
  // Destination sits in the top bits so a waveform shows it first
  typedef struct packed {
    logic [coordWidth-1:0]   destX;
    logic [coordWidth-1:0]   destY;
    // Incremented once on entry to every router
    logic [hopWidth-1:0]     hopCount;
    // Decremented when the packet leaves on an unproductive port
    logic [rerouteWidth-1:0] reroute;
    logic [payloadWidth-1:0] payload;
  } packetT;

endpackage
